//--- list.f
src/rename_pkg.sv
src/free_list.sv
src/map_table.sv
src/retire_map.sv
src/rename_stage.sv
testbench/rename_stage_tb.sv

//--- Bender.yml
package:
  name: rename_stage

sources:
  # Package first, then the blocks, then the top level
  - src/rename_pkg.sv
  - src/free_list.sv
  - src/map_table.sv
  - src/retire_map.sv
  - src/rename_stage.sv

  - target: test
    files:
      - testbench/rename_stage_tb.sv

//--- testbench/rename_stage_tb.sv
`timescale 1ns/100ps

module rename_stage_tb;

    import rename_pkg::*;

    localparam int arch_regs  = 1 << arch_width;
    localparam int test_steps = 2000;
    localparam int max_cycles = 8 * test_steps + 200;

    logic                  clock;
    logic                  reset;
    logic [lanes-1:0]      dispatch_en;
    logic [arch_width-1:0] src_a_arch [lanes];
    logic [arch_width-1:0] src_b_arch [lanes];
    logic [arch_width-1:0] dest_arch [lanes];
    logic [lanes-1:0]      retire_en;
    logic [arch_width-1:0] retire_arch [lanes];
    logic [phys_width-1:0] retire_phys [lanes];
    logic                  recover;

    logic                  ready;
    logic [phys_width-1:0] src_a_phys [lanes];
    logic [phys_width-1:0] src_b_phys [lanes];
    logic [phys_width-1:0] dest_phys [lanes];
    logic [ptr_width-1:0]  free_count;
    fl_state_t             fl_state;

    // Model of the rename state
    logic [phys_width-1:0] spec_map [arch_regs];
    logic [phys_width-1:0] comm_map [arch_regs];
    logic [phys_width-1:0] free_q [$];
    logic [arch_width-1:0] flight_arch [$];   // Dispatched, not yet retired
    logic [phys_width-1:0] flight_phys [$];

    // Expected responses for the group on the inputs
    logic                  exp_ready;
    logic [lanes-1:0]      exp_accept;
    logic [phys_width-1:0] exp_src_a [lanes];
    logic [phys_width-1:0] exp_src_b [lanes];
    logic [phys_width-1:0] exp_dest [lanes];
    logic [ptr_width-1:0]  exp_count;
    fl_state_t             exp_state;

    logic [31:0] lfsr;
    int value_errors = 0;
    int state_errors = 0;
    int checks = 0;
    int cycles = 0;

    rename_stage #(
        .lanes      (lanes),
        .arch_width (arch_width),
        .phys_width (phys_width)
    ) dut_i (
        .clock       (clock),
        .reset       (reset),
        .dispatch_en (dispatch_en),
        .src_a_arch  (src_a_arch),
        .src_b_arch  (src_b_arch),
        .dest_arch   (dest_arch),
        .ready       (ready),
        .src_a_phys  (src_a_phys),
        .src_b_phys  (src_b_phys),
        .dest_phys   (dest_phys),
        .retire_en   (retire_en),
        .retire_arch (retire_arch),
        .retire_phys (retire_phys),
        .recover     (recover),
        .free_count  (free_count),
        .fl_state    (fl_state)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic int unsigned rand_bits(input int width);
        int unsigned value;
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    task automatic reset_model();
        free_q.delete();
        flight_arch.delete();
        flight_phys.delete();
        for (int r = 0; r < arch_regs; r++) begin
            spec_map[r] = phys_width'(r);
            comm_map[r] = phys_width'(r);
        end
        for (int i = 0; i < fl_depth; i++) begin
            free_q.push_back(phys_width'(arch_regs + i));  // Tags above the identity set
        end
    endtask

    task automatic clear_inputs();
        dispatch_en = '0;
        retire_en   = '0;
        recover     = 1'b0;
        for (int n = 0; n < lanes; n++) begin
            src_a_arch[n]  = '0;
            src_b_arch[n]  = '0;
            dest_arch[n]   = '0;
            retire_arch[n] = '0;
            retire_phys[n] = '0;
        end
    endtask

    task automatic begin_cycle();
        @(negedge clock);
        clear_inputs();
    endtask

    task automatic random_regs();
        for (int n = 0; n < lanes; n++) begin
            src_a_arch[n] = arch_width'(rand_bits(arch_width));
            src_b_arch[n] = arch_width'(rand_bits(arch_width));
            dest_arch[n]  = arch_width'(rand_bits(arch_width));
        end
    endtask

    // Oldest in-flight instructions go to the selected lanes in lane order
    task automatic set_retire(input logic [lanes-1:0] mask);
        int next;
        next = 0;
        for (int n = 0; n < lanes; n++) begin
            if (mask[n] && next < flight_phys.size()) begin
                retire_en[n]   = 1'b1;
                retire_arch[n] = flight_arch[next];
                retire_phys[n] = flight_phys[next];
                next++;
            end
        end
    endtask

    task automatic predict();
        int rank;
        rank = 0;
        exp_ready  = !recover && (free_q.size() >= $countones(dispatch_en));
        exp_accept = exp_ready ? dispatch_en : '0;
        for (int n = 0; n < lanes; n++) begin
            exp_dest[n] = '0;
            if (exp_accept[n]) begin
                exp_dest[n] = free_q[rank];
                rank++;
            end
            exp_src_a[n] = spec_map[src_a_arch[n]];
            exp_src_b[n] = spec_map[src_b_arch[n]];
            for (int m = 0; m < n; m++) begin
                if (exp_accept[m] && dest_arch[m] == src_a_arch[n]) begin
                    exp_src_a[n] = exp_dest[m];
                end
                if (exp_accept[m] && dest_arch[m] == src_b_arch[n]) begin
                    exp_src_b[n] = exp_dest[m];
                end
            end
        end
        exp_count = ptr_width'(free_q.size());
        if (free_q.size() == 0) begin
            exp_state = fl_empty;
        end else if (free_q.size() == fl_depth) begin
            exp_state = fl_full;
        end else begin
            exp_state = fl_partial;
        end
    endtask

    task automatic advance_model();
        logic [phys_width-1:0] tag;
        if (recover) begin
            spec_map = comm_map;
            // Speculative tags return to the front of the free list in age order
            for (int i = flight_phys.size() - 1; i >= 0; i--) begin
                free_q.push_front(flight_phys[i]);
            end
            flight_arch.delete();
            flight_phys.delete();
        end else begin
            for (int n = 0; n < lanes; n++) begin
                if (exp_accept[n]) begin
                    tag = free_q.pop_front();
                    spec_map[dest_arch[n]] = tag;
                    flight_arch.push_back(dest_arch[n]);
                    flight_phys.push_back(tag);
                end
            end
            for (int n = 0; n < lanes; n++) begin
                if (retire_en[n]) begin
                    free_q.push_back(comm_map[retire_arch[n]]);
                    comm_map[retire_arch[n]] = retire_phys[n];
                    void'(flight_arch.pop_front());
                    void'(flight_phys.pop_front());
                end
            end
        end
    endtask

    task automatic check_value(input string name, input int lane, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            if (lane < 0) begin
                $display("FAIL t=%0t %s dut=%0d exp=%0d", $time, name, got, exp);
            end else begin
                $display("FAIL t=%0t %s[%0d] dut=%0d exp=%0d", $time, name, lane, got, exp);
            end
        end
    endtask

    task automatic compare_outputs();
        for (int n = 0; n < lanes; n++) begin
            check_value("src_a_phys", n, src_a_phys[n], exp_src_a[n]);
            check_value("src_b_phys", n, src_b_phys[n], exp_src_b[n]);
            if (exp_accept[n]) begin
                check_value("dest_phys", n, dest_phys[n], exp_dest[n]);
            end
        end
        check_value("free_count", -1, free_count, exp_count);
    endtask

    ready_check: assert property (@(posedge clock) disable iff (reset) ready === exp_ready)
        else begin
            state_errors++;
            $display("FAIL t=%0t ready dut=%0b exp=%0b", $time, $sampled(ready),
                     $sampled(exp_ready));
        end

    state_check: assert property (@(posedge clock) disable iff (reset) fl_state === exp_state)
        else begin
            state_errors++;
            $display("FAIL t=%0t fl_state dut=%0d exp=%0d", $time, $sampled(fl_state),
                     $sampled(exp_state));
        end

    // State moves in the NBA region so the outputs still show this cycle's values
    always @(posedge clock) begin
        if (!reset) begin
            compare_outputs();
            advance_model();
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        bit stalled;
        lfsr  = 32'he766;
        reset = 1'b1;
        clear_inputs();
        reset_model();
        predict();
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Identity lookups across all registers
        for (int c = 0; c < 6; c++) begin
            begin_cycle();
            for (int n = 0; n < lanes; n++) begin
                src_a_arch[n] = arch_width'(c * 2 * lanes + 2 * n);
                src_b_arch[n] = arch_width'(c * 2 * lanes + 2 * n + 1);
            end
            predict();
        end
        begin_cycle();
        dispatch_en = '1;  // First group takes 32, 33, 34
        random_regs();
        predict();

        // Lanes 0 and 1 both write r5 in one group
        begin_cycle();
        dispatch_en   = '1;
        src_a_arch[0] = 5'd5;
        dest_arch[0]  = 5'd5;
        src_a_arch[1] = 5'd5;
        src_b_arch[1] = 5'd9;
        dest_arch[1]  = 5'd5;
        src_a_arch[2] = 5'd5;
        src_b_arch[2] = 5'd7;
        dest_arch[2]  = 5'd7;
        predict();

        // Second group retires two lanes on the same register
        repeat (2) begin
            begin_cycle();
            src_a_arch[0] = 5'd5;  // Map holds the younger writer of r5
            set_retire('1);
            predict();
        end

        // Exhaustion with a stall when the group is too big
        stalled = 1'b0;
        while (free_q.size() > 0) begin
            begin_cycle();
            random_regs();
            if (free_q.size() >= lanes || !stalled) begin
                dispatch_en = '1;
                stalled = free_q.size() < lanes;
            end else begin
                dispatch_en = lanes'((1 << free_q.size()) - 1);
            end
            predict();
        end
        repeat (3) begin
            begin_cycle();
            random_regs();
            dispatch_en = '1;
            predict();
        end

        // Drain so later allocations reuse freed tags past the wrap
        while (flight_phys.size() > 0) begin
            begin_cycle();
            set_retire(lanes'(rand_bits(lanes)));
            predict();
        end

        // Recovery with speculative work in flight
        repeat (2) begin
            begin_cycle();
            random_regs();
            dispatch_en = '1;
            predict();
        end
        begin_cycle();
        set_retire(lanes'(3'b101));  // Gap on lane 1
        predict();
        begin_cycle();
        random_regs();
        dispatch_en = '1;
        recover = 1'b1;
        predict();
        begin_cycle();
        random_regs();
        dispatch_en = '1;
        predict();

        for (int step = 0; step < test_steps; step++) begin
            begin_cycle();
            random_regs();
            if (rand_bits(5) == 0) begin
                recover = 1'b1;
            end else begin
                set_retire(lanes'(rand_bits(lanes)));
            end
            dispatch_en = lanes'(rand_bits(lanes));
            predict();
        end

        begin_cycle();
        predict();
        @(negedge clock);

        $display("value errors: %0d, ready/state errors: %0d, checks: %0d",
                 value_errors, state_errors, checks);
        if (value_errors + state_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src/rename_stage.sv
`timescale 1ns/100ps

module rename_stage #(
    parameter int lanes      = rename_pkg::lanes,
    parameter int arch_width = rename_pkg::arch_width,
    parameter int phys_width = rename_pkg::phys_width
) (
    input  logic                              clock,
    input  logic                              reset,

    // Dispatch
    input  logic [lanes-1:0]                  dispatch_en,
    input  logic [arch_width-1:0]             src_a_arch [lanes],
    input  logic [arch_width-1:0]             src_b_arch [lanes],
    input  logic [arch_width-1:0]             dest_arch [lanes],
    output logic                              ready,
    output logic [phys_width-1:0]             src_a_phys [lanes],
    output logic [phys_width-1:0]             src_b_phys [lanes],
    output logic [phys_width-1:0]             dest_phys [lanes],

    // Retire
    input  logic [lanes-1:0]                  retire_en,
    input  logic [arch_width-1:0]             retire_arch [lanes],
    input  logic [phys_width-1:0]             retire_phys [lanes],

    input  logic                              recover,

    output logic [rename_pkg::ptr_width-1:0]  free_count,
    output rename_pkg::fl_state_t             fl_state
);

    import rename_pkg::*;

    logic [lanes-1:0]      accept;
    logic [phys_width-1:0] alloc_tag [lanes];
    logic [lanes-1:0]      freed_en;
    logic [phys_width-1:0] freed_tag [lanes];
    logic [ptr_width-1:0]  commit_head;
    logic [phys_width-1:0] committed_map [1 << arch_width];

    // Whole group or nothing
    assign ready  = !recover && (free_count >= ptr_width'($countones(dispatch_en)));
    assign accept = dispatch_en & {lanes{ready}};

    free_list #(
        .lanes      (lanes),
        .phys_width (phys_width)
    ) free_list_i (
        .clock       (clock),
        .reset       (reset),
        .accept      (accept),
        .freed_en    (freed_en),
        .freed_tag   (freed_tag),
        .recover     (recover),
        .commit_head (commit_head),
        .alloc_tag   (alloc_tag),
        .free_count  (free_count),
        .fl_state    (fl_state)
    );

    map_table #(
        .lanes      (lanes),
        .arch_width (arch_width),
        .phys_width (phys_width)
    ) map_table_i (
        .clock         (clock),
        .reset         (reset),
        .accept        (accept),
        .src_a_arch    (src_a_arch),
        .src_b_arch    (src_b_arch),
        .dest_arch     (dest_arch),
        .alloc_tag     (alloc_tag),
        .recover       (recover),
        .committed_map (committed_map),
        .src_a_phys    (src_a_phys),
        .src_b_phys    (src_b_phys),
        .dest_phys     (dest_phys)
    );

    retire_map #(
        .lanes      (lanes),
        .arch_width (arch_width),
        .phys_width (phys_width)
    ) retire_map_i (
        .clock         (clock),
        .reset         (reset),
        .retire_en     (retire_en),
        .retire_arch   (retire_arch),
        .retire_phys   (retire_phys),
        .freed_en      (freed_en),
        .freed_tag     (freed_tag),
        .commit_head   (commit_head),
        .committed_map (committed_map)
    );

endmodule

//--- src/retire_map.sv
`timescale 1ns/100ps

module retire_map #(
    parameter int lanes      = rename_pkg::lanes,
    parameter int arch_width = rename_pkg::arch_width,
    parameter int phys_width = rename_pkg::phys_width
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [lanes-1:0]                  retire_en,
    input  logic [arch_width-1:0]             retire_arch [lanes],
    input  logic [phys_width-1:0]             retire_phys [lanes],
    output logic [lanes-1:0]                  freed_en,
    output logic [phys_width-1:0]             freed_tag [lanes],
    output logic [rename_pkg::ptr_width-1:0]  commit_head,
    output logic [phys_width-1:0]             committed_map [1 << arch_width]
);

    import rename_pkg::*;

    localparam int arch_regs = 1 << arch_width;

    logic [ptr_width-1:0] retire_cnt;

    assign retire_cnt = ptr_width'($countones(retire_en));

    // Every retiring instruction releases exactly one old tag
    assign freed_en = retire_en;

    // Old tag comes from the array or from an older lane of this group
    always_comb begin
        for (int n = 0; n < lanes; n++) begin
            freed_tag[n] = committed_map[retire_arch[n]];
            for (int m = 0; m < n; m++) begin
                if (retire_en[m] && retire_arch[m] == retire_arch[n]) begin
                    freed_tag[n] = retire_phys[m];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_head <= fl_reset_head;
            for (int r = 0; r < arch_regs; r++) begin
                committed_map[r] <= phys_width'(r);
            end
        end else begin
            commit_head <= commit_head + retire_cnt;  // Wraps with the free list
            for (int n = 0; n < lanes; n++) begin
                if (retire_en[n]) begin
                    committed_map[retire_arch[n]] <= retire_phys[n];
                end
            end
        end
    end

endmodule

//--- src/map_table.sv
`timescale 1ns/100ps

module map_table #(
    parameter int lanes      = rename_pkg::lanes,
    parameter int arch_width = rename_pkg::arch_width,
    parameter int phys_width = rename_pkg::phys_width
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [lanes-1:0]       accept,
    input  logic [arch_width-1:0]  src_a_arch [lanes],
    input  logic [arch_width-1:0]  src_b_arch [lanes],
    input  logic [arch_width-1:0]  dest_arch [lanes],
    input  logic [phys_width-1:0]  alloc_tag [lanes],
    input  logic                   recover,
    input  logic [phys_width-1:0]  committed_map [1 << arch_width],
    output logic [phys_width-1:0]  src_a_phys [lanes],
    output logic [phys_width-1:0]  src_b_phys [lanes],
    output logic [phys_width-1:0]  dest_phys [lanes]
);

    localparam int arch_regs = 1 << arch_width;

    logic [phys_width-1:0] spec_map [arch_regs];

    // Lane n takes the tag of its rank among the accepted lanes
    always_comb begin
        int rank;
        rank = 0;
        for (int n = 0; n < lanes; n++) begin
            dest_phys[n] = alloc_tag[rank];
            if (accept[n]) begin
                rank++;
            end
        end
    end

    // Source lookup with bypass from older lanes of the same group
    always_comb begin
        for (int n = 0; n < lanes; n++) begin
            src_a_phys[n] = spec_map[src_a_arch[n]];
            src_b_phys[n] = spec_map[src_b_arch[n]];

            // Ascending scan leaves the youngest older writer in place
            for (int m = 0; m < n; m++) begin
                if (accept[m] && dest_arch[m] == src_a_arch[n]) begin
                    src_a_phys[n] = dest_phys[m];
                end
                if (accept[m] && dest_arch[m] == src_b_arch[n]) begin
                    src_b_phys[n] = dest_phys[m];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_regs; r++) begin
                spec_map[r] <= phys_width'(r);  // Identity mapping
            end
        end else if (recover) begin
            spec_map <= committed_map;
        end else begin
            // Later lanes overwrite earlier ones on the same register
            for (int n = 0; n < lanes; n++) begin
                if (accept[n]) begin
                    spec_map[dest_arch[n]] <= dest_phys[n];
                end
            end
        end
    end

endmodule

//--- src/free_list.sv
`timescale 1ns/100ps

module free_list #(
    parameter int lanes      = rename_pkg::lanes,
    parameter int phys_width = rename_pkg::phys_width
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [lanes-1:0]                  accept,
    input  logic [lanes-1:0]                  freed_en,
    input  logic [phys_width-1:0]             freed_tag [lanes],
    input  logic                              recover,
    input  logic [rename_pkg::ptr_width-1:0]  commit_head,
    output logic [phys_width-1:0]             alloc_tag [lanes],
    output logic [rename_pkg::ptr_width-1:0]  free_count,
    output rename_pkg::fl_state_t             fl_state
);

    import rename_pkg::*;

    localparam int idx_width = ptr_width - 1;

    logic [phys_width-1:0] fl_mem [fl_depth];

    logic [ptr_width-1:0] head;
    logic [ptr_width-1:0] tail;
    logic [idx_width-1:0] head_idx;
    logic [idx_width-1:0] tail_idx;

    logic [ptr_width-1:0] accept_cnt;
    logic [ptr_width-1:0] freed_cnt;
    logic [idx_width-1:0] wr_idx [lanes];

    assign head_idx = head[idx_width-1:0];
    assign tail_idx = tail[idx_width-1:0];

    assign accept_cnt = ptr_width'($countones(accept));
    assign freed_cnt  = ptr_width'($countones(freed_en));

    // Wrap bit makes the difference exact from 0 up to fl_depth
    assign free_count = tail - head;

    always_comb begin
        if (free_count == '0) begin
            fl_state = fl_empty;
        end else if (free_count == ptr_width'(fl_depth)) begin
            fl_state = fl_full;
        end else begin
            fl_state = fl_partial;
        end
    end

    // Next tags to hand out, oldest first
    always_comb begin
        for (int k = 0; k < lanes; k++) begin
            alloc_tag[k] = fl_mem[idx_width'(head_idx + k)];
        end
    end

    // Compact the freed tags so they land back to back at the tail
    always_comb begin
        int slot;
        slot = 0;
        for (int n = 0; n < lanes; n++) begin
            wr_idx[n] = idx_width'(tail_idx + slot);
            if (freed_en[n]) begin
                slot++;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= fl_reset_head;
            tail <= fl_reset_tail;
            for (int i = 0; i < fl_depth; i++) begin
                fl_mem[i] <= phys_width'(fl_tag_base + i);
            end
        end else if (recover) begin
            head <= commit_head;  // Drop every speculative allocation
        end else begin
            head <= head + accept_cnt;
            tail <= tail + freed_cnt;
            for (int n = 0; n < lanes; n++) begin
                if (freed_en[n]) begin
                    fl_mem[wr_idx[n]] <= freed_tag[n];
                end
            end
        end
    end

endmodule

//--- src/rename_pkg.sv
package rename_pkg;

    // Machine widths
    parameter int lanes      = 3;  // Dispatch and retire width
    parameter int arch_width = 5;
    parameter int phys_width = 6;

    // Free list geometry
    parameter int fl_depth  = 32;
    parameter int ptr_width = 6;   // Top bit is the wrap bit

    // First tag held by the free list out of reset
    // Tags below this are the initial identity mappings
    parameter int fl_tag_base = 32;

    // Pointer values out of reset
    parameter logic [ptr_width-1:0] fl_reset_head = '0;
    parameter logic [ptr_width-1:0] fl_reset_tail = ptr_width'(fl_depth);

    // Occupancy of the free list
    typedef enum logic [1:0] {
        fl_empty,
        fl_partial,
        fl_full
    } fl_state_t;

endpackage
